// File: dhcp_config.svh
`ifndef DHCP_CONFIG_SVH
`define DHCP_CONFIG_SVH

// client hardware address, locally administered.
`define DHCP_MAC_ADDR 48'h02_1a_c4_5e_00_17

// clock cycles to wait for a reply before starting over.
`define DHCP_TIMEOUT_TICKS 200

// extra attempts after the first discover.
`define DHCP_RETRIES 3

// reset value of the transaction id lfsr, must be nonzero.
`define DHCP_XID_SEED 32'h5eed_c0de

`endif

// File: dhcp_pkg.sv
`default_nettype none

package dhcp_pkg;

  typedef logic [31:0] ipv4_t;
  typedef logic [47:0] mac_t;
  typedef logic [31:0] xid_t;

  // bootp op codes.
  localparam logic [7:0] BOOT_REQUEST = 8'd1;
  localparam logic [7:0] BOOT_REPLY   = 8'd2;

  // dhcp message type option values.
  localparam logic [7:0] MSG_DISCOVER = 8'd1;
  localparam logic [7:0] MSG_OFFER    = 8'd2;
  localparam logic [7:0] MSG_REQUEST  = 8'd3;
  localparam logic [7:0] MSG_ACK      = 8'd5;

  // one parsed dhcp message, header fields and the options we care about.
  typedef struct packed {
    logic [7:0]  op;
    xid_t        xid;
    logic [15:0] flags;
    ipv4_t       yiaddr;     // your (offered) address.
    ipv4_t       siaddr;     // server address.
    mac_t        chaddr;
    logic [7:0]  msg_type;
    logic        type_pres;
    ipv4_t       req_ip;
    ipv4_t       srv_id;
    logic        router_pres;
    ipv4_t       router;
    logic        mask_pres;
    ipv4_t       mask;
  } dhcp_msg_t;

  typedef struct packed {
    logic  send;
    logic  is_request;
    xid_t  xid;
    ipv4_t req_ip;
    ipv4_t srv_id;
  } dhcp_cmd_t;

  typedef struct packed {
    logic  offer_hit;
    logic  ack_hit;
    ipv4_t yiaddr;
    ipv4_t siaddr;
    logic  router_val;
    ipv4_t router;
    logic  mask_val;
    ipv4_t mask;
  } dhcp_lease_t;

  typedef struct packed {
    logic       busy;
    logic       success;
    logic       fail;
    logic [3:0] try_cnt;
    ipv4_t      assig_ip;
    logic       router_val;
    ipv4_t      router;
    logic       mask_val;
    ipv4_t      mask;
  } dhcp_status_t;

  typedef enum logic [2:0] {
    idle_s,
    discover_s,
    offer_s,
    request_s,
    ack_s
  } dhcp_state_t;

endpackage

`default_nettype wire

// File: dhcp_xid_lfsr.sv
`timescale 1ns/1ps
`default_nettype none
`include "dhcp_config.svh"

module dhcp_xid_lfsr import dhcp_pkg::*; (
  input  logic clk,
  input  logic rst,
  output xid_t xid
);

  // x^32 + x^22 + x^2 + x + 1, maximal length.
  localparam xid_t TAPS = 32'h8020_0003;

  // runs every cycle, so the value picked up at a discover depends on
  // how long the host took to start us.
  always_ff @(posedge clk) begin
    if (rst) begin
      xid <= `DHCP_XID_SEED;
    end else begin
      xid <= (xid >> 1) ^ ({32{xid[0]}} & TAPS); // galois step.
    end
  end

endmodule

`default_nettype wire

// File: dhcp_tmr.sv
`timescale 1ns/1ps
`default_nettype none
`include "dhcp_config.svh"

module dhcp_tmr (
  input  logic clk,
  input  logic rst,
  input  logic en,
  input  logic clr,
  output logic expired
);

  localparam int CW = $clog2(`DHCP_TIMEOUT_TICKS + 1);

  logic [CW-1:0] cnt;

  always_ff @(posedge clk) begin
    if (rst || clr) begin
      cnt     <= '0;
      expired <= 1'b0;
    end else if (en && cnt == CW'(`DHCP_TIMEOUT_TICKS - 1)) begin
      cnt     <= '0; // wrap and start the next period.
      expired <= 1'b1;
    end else begin
      cnt     <= en ? cnt + 1'b1 : cnt;
      expired <= 1'b0;
    end
  end

  a_single_expiry: assert property (@(posedge clk) disable iff (rst) expired |=> !expired);

endmodule

`default_nettype wire

// File: dhcp_tx_build.sv
`timescale 1ns/1ps
`default_nettype none
`include "dhcp_config.svh"

module dhcp_tx_build import dhcp_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  dhcp_cmd_t cmd,
  output logic      tx_val,
  output dhcp_msg_t tx_msg
);

  always_ff @(posedge clk) begin
    if (rst) begin
      tx_val <= 1'b0;
    end else begin
      tx_val <= cmd.send; // one cycle behind the command.
    end
  end

  // message body, only loaded on a send.
  always_ff @(posedge clk) begin
    if (cmd.send) begin
      tx_msg.op        <= BOOT_REQUEST;
      tx_msg.xid       <= cmd.xid;
      tx_msg.flags     <= 16'h8000; // broadcast, we have no address yet.
      tx_msg.yiaddr    <= '0;
      tx_msg.siaddr    <= '0;
      tx_msg.chaddr    <= `DHCP_MAC_ADDR;
      tx_msg.msg_type  <= cmd.is_request ? MSG_REQUEST : MSG_DISCOVER;
      tx_msg.type_pres <= 1'b1;
      tx_msg.req_ip    <= cmd.req_ip;
      // server id only tells the chosen server apart in a request.
      tx_msg.srv_id      <= cmd.is_request ? cmd.srv_id : '0;
      tx_msg.router_pres <= 1'b0;
      tx_msg.router      <= '0;
      tx_msg.mask_pres   <= 1'b0;
      tx_msg.mask        <= '0;
    end
  end

  a_send_gap: assert property (@(posedge clk) disable iff (rst) cmd.send |=> !cmd.send);

endmodule

`default_nettype wire

// File: dhcp_rx_filter.sv
`timescale 1ns/1ps
`default_nettype none

module dhcp_rx_filter import dhcp_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        rx_val,
  input  dhcp_msg_t   rx_msg,
  input  xid_t        cur_xid,
  output dhcp_lease_t lease
);

  logic  match;
  logic  offer_hit, ack_hit;
  logic  router_val, mask_val;
  ipv4_t yiaddr, siaddr, router, mask;

  // a reply to our own transaction with a message type option.
  assign match = rx_val && rx_msg.op == BOOT_REPLY && rx_msg.xid == cur_xid &&
                 rx_msg.type_pres;

  always_ff @(posedge clk) begin
    if (rst) begin
      offer_hit <= 1'b0;
      ack_hit   <= 1'b0;
    end else begin
      offer_hit <= match && rx_msg.msg_type == MSG_OFFER;
      ack_hit   <= match && rx_msg.msg_type == MSG_ACK;
    end
  end

  always_ff @(posedge clk) begin
    if (match) begin
      yiaddr     <= rx_msg.yiaddr;
      siaddr     <= rx_msg.siaddr;
      router_val <= rx_msg.router_pres;
      router     <= rx_msg.router;
      mask_val   <= rx_msg.mask_pres;
      mask       <= rx_msg.mask;
    end
  end

  assign lease = '{offer_hit: offer_hit, ack_hit: ack_hit, yiaddr: yiaddr, siaddr: siaddr,
                   router_val: router_val, router: router, mask_val: mask_val, mask: mask};

endmodule

`default_nettype wire

// File: dhcp_core.sv
`timescale 1ns/1ps
`default_nettype none
`include "dhcp_config.svh"

module dhcp_core import dhcp_pkg::*; (
  input  logic         clk,
  input  logic         rst,
  input  logic         start,
  input  ipv4_t        pref_ip,
  input  dhcp_lease_t  lease,
  input  xid_t         xid_rand,
  input  logic         tmr_expired,
  output logic         tmr_en,
  output logic         tmr_clr,
  output dhcp_cmd_t    cmd,
  output xid_t         cur_xid,
  output dhcp_status_t status
);

  dhcp_state_t state;
  logic [3:0]  try_cnt;
  logic        success, fail, send, is_req;
  logic        router_val, mask_val;
  ipv4_t       req_ip, server_ip, assig_ip, router, mask;
  logic        waiting, late, last_try, go_disc, go_req, go_done, go_fail;

  assign waiting  = state == offer_s || state == ack_s;
  assign last_try = try_cnt == 4'(`DHCP_RETRIES);
  assign go_req   = state == offer_s && lease.offer_hit;
  assign go_done  = state == ack_s && lease.ack_hit;
  assign late     = waiting && tmr_expired && !go_req && !go_done; // a hit wins.
  assign go_fail  = late && last_try;
  assign go_disc  = (state == idle_s && start) || (late && !last_try);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= idle_s;
    end else begin
      unique case (state)
        idle_s:     state <= go_disc ? discover_s : idle_s;
        discover_s: state <= offer_s;
        offer_s:    state <= go_req ? request_s : go_disc ? discover_s :
                             go_fail ? idle_s : offer_s;
        request_s:  state <= ack_s;
        ack_s:      state <= go_done || go_fail ? idle_s : go_disc ? discover_s : ack_s;
        default:    state <= idle_s;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      try_cnt <= '0;
      success <= 1'b0;
      fail    <= 1'b0;
      tmr_en  <= 1'b0;
      tmr_clr <= 1'b0;
      send    <= 1'b0;
      is_req  <= 1'b0;
    end else begin
      send    <= go_disc || go_req;
      tmr_clr <= go_disc || go_req; // every send gets a full timeout.
      is_req  <= go_req ? 1'b1 : go_disc ? 1'b0 : is_req;
      if (state == idle_s && start) begin
        try_cnt <= '0;
        success <= 1'b0;
        fail    <= 1'b0;
        tmr_en  <= 1'b1;
      end else if (go_disc) begin
        try_cnt <= try_cnt + 1'b1; // retry after a timeout.
      end
      if (go_done) begin
        success <= 1'b1;
        tmr_en  <= 1'b0;
      end
      if (go_fail) begin
        fail   <= 1'b1;
        tmr_en <= 1'b0;
      end
    end
  end

  // transaction and the addresses to request.
  always_ff @(posedge clk) begin
    if (go_disc) begin
      cur_xid <= xid_rand;
      req_ip  <= pref_ip;
    end else if (go_req) begin
      req_ip    <= lease.yiaddr; // the offered address.
      server_ip <= lease.siaddr;
    end
  end

  always_ff @(posedge clk) begin
    if (rst || (state == idle_s && start)) begin
      assig_ip   <= '0;
      router_val <= 1'b0;
      router     <= '0;
      mask_val   <= 1'b0;
      mask       <= '0;
    end else if (go_done) begin
      assig_ip   <= lease.yiaddr;
      router_val <= lease.router_val;
      router     <= lease.router_val ? lease.router : '0;
      mask_val   <= lease.mask_val;
      mask       <= lease.mask_val ? lease.mask : '0;
    end
  end

  assign cmd = '{send: send, is_request: is_req, xid: cur_xid, req_ip: req_ip,
                 srv_id: server_ip};

  assign status = '{busy: state != idle_s, success: success, fail: fail, try_cnt: try_cnt,
                    assig_ip: assig_ip, router_val: router_val, router: router,
                    mask_val: mask_val, mask: mask};

  a_one_result: assert property (@(posedge clk) disable iff (rst) !(success && fail));
  a_send_state: assert property (@(posedge clk) disable iff (rst)
    cmd.send |-> state inside {discover_s, request_s});

endmodule

`default_nettype wire

// File: dhcp_regs.sv
`timescale 1ns/1ps
`default_nettype none

module dhcp_regs import dhcp_pkg::*; (
  input  logic         clk,
  input  logic         rst,
  input  logic         cyc,
  input  logic         stb,
  input  logic         we,
  input  logic [2:0]   adr,
  input  logic [31:0]  dat_i,
  output logic [31:0]  dat_o,
  output logic         ack,
  output logic         start,
  output ipv4_t        pref_ip,
  input  dhcp_status_t status
);

  logic        done;
  logic        req;
  logic [31:0] rd_word;

  // new cycle only once the last one has been acked and stb dropped.
  assign req = cyc && stb && !ack && !done;

  always_ff @(posedge clk) begin
    if (rst) begin
      ack  <= 1'b0;
      done <= 1'b0;
    end else begin
      ack  <= req;
      done <= ack ? 1'b1 : (stb ? done : 1'b0);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      start   <= 1'b0;
      pref_ip <= '0;
    end else begin
      start <= req && we && adr == 3'd0 && dat_i[0]; // lands in the ack cycle.
      if (req && we && adr == 3'd1) begin
        pref_ip <= dat_i;
      end
    end
  end

  always_comb begin
    case (adr)
      3'd1:    rd_word = pref_ip;
      3'd2:    rd_word = {status.router_val, status.mask_val, 22'd0, status.try_cnt,
                          1'b0, status.fail, status.success, status.busy};
      3'd3:    rd_word = status.assig_ip;
      3'd4:    rd_word = status.router;
      3'd5:    rd_word = status.mask;
      default: rd_word = '0; // control is write only.
    endcase
  end

  always_ff @(posedge clk) begin
    if (req && !we) begin
      dat_o <= rd_word;
    end
  end

endmodule

`default_nettype wire

// File: dhcp_client_top.sv
`timescale 1ns/1ps
`default_nettype none

module dhcp_client_top import dhcp_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        cyc,
  input  logic        stb,
  input  logic        we,
  input  logic [2:0]  adr,
  input  logic [31:0] dat_i,
  output logic [31:0] dat_o,
  output logic        ack,
  input  logic        rx_val,
  input  dhcp_msg_t   rx_msg,
  output logic        tx_val,
  output dhcp_msg_t   tx_msg
);

  logic         start;
  ipv4_t        pref_ip;
  dhcp_status_t status;
  dhcp_lease_t  lease;
  dhcp_cmd_t    cmd;
  xid_t         xid_rand;
  xid_t         cur_xid;
  logic         tmr_en;
  logic         tmr_clr;
  logic         tmr_expired;

  dhcp_regs regs_inst (
    .clk, .rst, .cyc, .stb, .we, .adr, .dat_i, .dat_o, .ack,
    .start, .pref_ip, .status
  );

  dhcp_core core_inst (
    .clk, .rst, .start, .pref_ip, .lease, .xid_rand, .tmr_expired,
    .tmr_en, .tmr_clr, .cmd, .cur_xid, .status
  );

  dhcp_xid_lfsr lfsr_inst (.clk, .rst, .xid(xid_rand));

  dhcp_tmr tmr_inst (.clk, .rst, .en(tmr_en), .clr(tmr_clr), .expired(tmr_expired));

  dhcp_tx_build tx_inst (.clk, .rst, .cmd, .tx_val, .tx_msg);

  dhcp_rx_filter rx_inst (.clk, .rst, .rx_val, .rx_msg, .cur_xid, .lease);

endmodule

`default_nettype wire

// File: tb_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk; // 8 ns period.
  end

  initial begin
    rst = 1'b1;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  end

endmodule

`default_nettype wire

// File: tb_dhcp.sv
`timescale 1ns/1ps
`default_nettype none
`include "dhcp_config.svh"

module tb_dhcp import dhcp_pkg::*; ();

  localparam int RUNS    = 12;
  localparam int RETRIES = `DHCP_RETRIES;
  localparam int TICKS   = `DHCP_TIMEOUT_TICKS;
  localparam int LIMIT   = RUNS * (RETRIES + 2) * (TICKS + 50);

  logic        clk, rst, cyc, stb, we, ack, rx_val, tx_val;
  logic [2:0]  adr;
  logic [31:0] dat_i, dat_o;
  dhcp_msg_t   rx_msg, tx_msg;

  // stimulus choices for the current run.
  int    ignore_n, decoy_kind, d_decoy, d_real;
  ipv4_t pref, offer_ip, server_ip, rtr, msk;
  logic  rtr_pres, msk_pres;

  // server model state.
  int        now = 0;
  int        disc_cnt = 0;
  int        disc_base = 0;
  int        req_cnt = 0;
  xid_t      last_xid;
  logic      offer_sent;
  dhcp_msg_t sched_msg[$];
  int        sched_at[$];
  bit        sched_real[$];

  int cycles = 0;

  tb_clkgen clkgen_inst (.clk, .rst);

  dhcp_client_top UUT (
    .clk, .rst, .cyc, .stb, .we, .adr, .dat_i, .dat_o, .ack,
    .rx_val, .rx_msg, .tx_val, .tx_msg
  );

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("MISMATCH %s: expected 0x%08h, got 0x%08h", name, exp, act);
      $display("Test FAILED");
      $fatal(1, "check failed");
    end
  endtask

  // one wishbone classic cycle started on a falling edge.
  task automatic bus_xfer(input logic w, input logic [2:0] a, input logic [31:0] d,
                          output logic [31:0] q);
    cyc   = 1'b1;
    stb   = 1'b1;
    we    = w;
    adr   = a;
    dat_i = d;
    do @(negedge clk); while (!ack);
    q   = dat_o;
    cyc = 1'b0;
    stb = 1'b0;
    we  = 1'b0;
    repeat (2) @(negedge clk); // slave needs stb low before the next request.
  endtask

  function automatic dhcp_msg_t server_reply(input logic [7:0] mtype);
    dhcp_msg_t r;
    r             = '0;
    r.op          = BOOT_REPLY;
    r.xid         = last_xid;
    r.flags       = 16'h8000;
    r.yiaddr      = offer_ip;
    r.siaddr      = server_ip;
    r.chaddr      = `DHCP_MAC_ADDR;
    r.msg_type    = mtype;
    r.type_pres   = 1'b1;
    r.srv_id      = server_ip;
    r.router_pres = rtr_pres;
    r.router      = rtr;
    r.mask_pres   = msk_pres;
    r.mask        = msk;
    return r;
  endfunction

  task automatic push_reply(input logic [7:0] mtype, input logic answer);
    dhcp_msg_t r;
    dhcp_msg_t d;
    r = server_reply(mtype);
    if (decoy_kind != 0) begin
      d             = r;
      d.yiaddr      = ~offer_ip; // a decoy taken by mistake shows in the results.
      d.router_pres = 1'b1;
      d.router      = ~rtr;
      case (decoy_kind)
        1:       d.xid = ~last_xid;
        2:       d.op = BOOT_REQUEST;
        3:       d.type_pres = 1'b0;
        default: d.msg_type = (mtype == MSG_OFFER) ? MSG_ACK : MSG_OFFER;
      endcase
      sched_msg.push_back(d);
      sched_at.push_back(now + d_decoy);
      sched_real.push_back(1'b0);
    end
    if (answer) begin
      sched_msg.push_back(r);
      sched_at.push_back(now + d_decoy + d_real);
      sched_real.push_back(1'b1);
    end
  endtask

  task automatic serve(input dhcp_msg_t m);
    check_val("tx.op", 32'(BOOT_REQUEST), 32'(m.op));
    check_val("tx.flags", 32'h8000, 32'(m.flags));
    check_val("tx.chaddr_hi", 32'(`DHCP_MAC_ADDR >> 32), 32'(m.chaddr[47:32]));
    check_val("tx.chaddr_lo", 32'(`DHCP_MAC_ADDR), m.chaddr[31:0]);
    check_val("tx.type_pres", 32'd1, 32'(m.type_pres));
    check_val("tx.yiaddr", 32'd0, m.yiaddr);
    check_val("tx.siaddr", 32'd0, m.siaddr);
    check_val("tx.opt_pres", 32'd0, 32'({m.router_pres, m.mask_pres}));
    check_val("tx.router", 32'd0, m.router);
    check_val("tx.mask", 32'd0, m.mask);
    if (m.msg_type == MSG_DISCOVER) begin
      disc_cnt   = disc_cnt + 1;
      last_xid   = m.xid;
      offer_sent = 1'b0;
      check_val("tx.req_ip", pref, m.req_ip);
      check_val("tx.srv_id", 32'd0, m.srv_id);
      push_reply(MSG_OFFER, (disc_cnt - disc_base) > ignore_n);
    end else begin
      check_val("tx.msg_type", 32'(MSG_REQUEST), 32'(m.msg_type));
      req_cnt = req_cnt + 1;
      check_val("offer before request", 32'd1, 32'(offer_sent));
      check_val("tx.xid", last_xid, m.xid);
      check_val("tx.req_ip", offer_ip, m.req_ip);
      check_val("tx.srv_id", server_ip, m.srv_id);
      push_reply(MSG_ACK, 1'b1);
    end
  endtask

  initial begin : server_model
    rx_val = 1'b0;
    rx_msg = '0;
    forever begin
      @(negedge clk);
      rx_val = 1'b0;
      now = now + 1;
      if (sched_at.size() > 0 && sched_at[0] == now) begin
        void'(sched_at.pop_front());
        rx_msg = sched_msg.pop_front();
        rx_val = 1'b1;
        if (sched_real.pop_front() && rx_msg.msg_type == MSG_OFFER) offer_sent = 1'b1;
      end
      if (tx_val) serve(tx_msg);
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= LIMIT) begin
      $display("TIMEOUT: no result after %0d cycles", cycles);
      $display("Test FAILED");
      $fatal(1, "simulation hung");
    end
  end

  initial begin
    logic [31:0] rd, exp_stat;
    logic        exp_fail;
    int          exp_try, req_base;
    void'($urandom(69224));
    cyc   = 1'b0;
    stb   = 1'b0;
    we    = 1'b0;
    adr   = 3'd0;
    dat_i = 32'd0;
    pref  = 32'd0;
    ignore_n = 0;
    decoy_kind = 0;
    while (rst !== 1'b0) @(negedge clk);
    for (int a = 2; a <= 5; a++) begin
      bus_xfer(1'b0, 3'(a), 32'd0, rd);
      check_val($sformatf("reg%0d after reset", a), 32'd0, rd);
    end
    repeat (4) begin
      pref = $urandom;
      bus_xfer(1'b1, 3'd1, pref, rd);
      bus_xfer(1'b0, 3'd1, 32'd0, rd);
      check_val("pref_ip", pref, rd);
    end
    for (int run = 0; run < RUNS; run++) begin
      ignore_n   = (run % 4 == 3) ? RETRIES + 1 : int'($urandom_range(0, RETRIES));
      decoy_kind = int'($urandom_range(0, 4));
      d_decoy    = int'($urandom_range(2, 70));
      d_real     = int'($urandom_range(2, 70));
      pref       = $urandom;
      offer_ip   = $urandom;
      server_ip  = $urandom;
      rtr        = $urandom;
      msk        = $urandom;
      rtr_pres   = 1'($urandom_range(0, 1));
      msk_pres   = 1'($urandom_range(0, 1));
      bus_xfer(1'b1, 3'd1, pref, rd);
      disc_base = disc_cnt;
      req_base  = req_cnt;
      bus_xfer(1'b1, 3'd0, 32'd1, rd);
      if (run % 3 == 1) bus_xfer(1'b1, 3'd0, 32'd1, rd); // start while busy.
      bus_xfer(1'b0, 3'd2, 32'd0, rd);
      check_val("status after start", 32'h1, rd & 32'hc000_00f7);
      bus_xfer(1'b0, 3'd3, 32'd0, rd);
      check_val("assig_ip after start", 32'd0, rd);
      do bus_xfer(1'b0, 3'd2, 32'd0, rd); while (rd[2:1] == 2'b00);
      exp_fail = ignore_n > RETRIES;
      exp_try  = exp_fail ? RETRIES : ignore_n;
      exp_stat = {!exp_fail && rtr_pres, !exp_fail && msk_pres, 22'd0, 4'(exp_try),
                  1'b0, exp_fail, !exp_fail, 1'b0};
      check_val("status", exp_stat, rd);
      check_val("discover count", 32'(exp_try + 1), 32'(disc_cnt - disc_base));
      check_val("request count", exp_fail ? 32'd0 : 32'd1, 32'(req_cnt - req_base));
      bus_xfer(1'b0, 3'd3, 32'd0, rd);
      check_val("assig_ip", exp_fail ? 32'd0 : offer_ip, rd);
      if (!exp_fail && rtr_pres) begin
        bus_xfer(1'b0, 3'd4, 32'd0, rd);
        check_val("router", rtr, rd);
      end
      if (!exp_fail && msk_pres) begin
        bus_xfer(1'b0, 3'd5, 32'd0, rd);
        check_val("mask", msk, rd);
      end
    end
    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
+incdir+.
dhcp_pkg.sv
dhcp_xid_lfsr.sv
dhcp_tmr.sv
dhcp_tx_build.sv
dhcp_rx_filter.sv
dhcp_core.sv
dhcp_regs.sv
dhcp_client_top.sv
tb_clkgen.sv
tb_dhcp.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_dhcp
FILELIST  ?= tb.f
OBJDIR    ?= obj_dir
PASS_MSG  := Test OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

$(OBJDIR)/V$(TOP): $(shell cat $(FILELIST) | grep -v '^+') dhcp_config.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

sim: $(OBJDIR)/V$(TOP)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
